// ==== build.f ====
common/csr_pkg.sv
source/csr_write_stage.sv
exception/csr_exc_regs.sv
timer/csr_timer.sv
source/csr_save_regs.sv
source/csr_read_mux.sv
source/csr_top.sv
verif/csr_chk.sv
verif/csr_tb.sv

// ==== common/csr_pkg.sv ====
package csr_pkg;

    localparam int CSR_ADDR_W = 14;
    localparam int CSR_DATA_W = 32;

    // CSR address map
    localparam logic [CSR_ADDR_W-1:0] CSR_CRMD   = 14'h000;
    localparam logic [CSR_ADDR_W-1:0] CSR_PRMD   = 14'h001;
    localparam logic [CSR_ADDR_W-1:0] CSR_ECFG   = 14'h004;
    localparam logic [CSR_ADDR_W-1:0] CSR_ESTAT  = 14'h005;
    localparam logic [CSR_ADDR_W-1:0] CSR_ERA    = 14'h006;
    localparam logic [CSR_ADDR_W-1:0] CSR_BADV   = 14'h007;
    localparam logic [CSR_ADDR_W-1:0] CSR_EENTRY = 14'h00c;
    localparam logic [CSR_ADDR_W-1:0] CSR_SAVE0  = 14'h030;
    localparam logic [CSR_ADDR_W-1:0] CSR_TID    = 14'h040;
    localparam logic [CSR_ADDR_W-1:0] CSR_TCFG   = 14'h041;
    localparam logic [CSR_ADDR_W-1:0] CSR_TVAL   = 14'h042;
    localparam logic [CSR_ADDR_W-1:0] CSR_TICLR  = 14'h044;

    localparam logic [5:0]  ECODE_TLBR = 6'h3f;
    // Bit 10 is reserved in ECFG.LIE
    localparam logic [12:0] LIE_MASK   = 13'h1bff;

    localparam logic [CSR_DATA_W-1:0] CRMD_RESET = 32'h0000_0068;

    typedef struct packed {
        logic                  en;
        logic [CSR_ADDR_W-1:0] addr;
        logic [CSR_DATA_W-1:0] data;
    } csr_wr_t;

    typedef struct packed {
        logic [22:0] zero;
        logic [1:0]  datm;
        logic [1:0]  datf;
        logic        pg;
        logic        da;
        logic        ie;
        logic [1:0]  plv;
    } crmd_t;

    typedef struct packed {
        logic        zero_31;
        logic [8:0]  esubcode;
        logic [5:0]  ecode;
        logic [2:0]  zero_15_13;
        logic        ipi;
        logic        is_ti;
        logic        zero_10;
        logic [7:0]  is_hard;
        logic [1:0]  is_soft;
    } estat_t;

    typedef struct packed {
        logic        exception;
        logic        ertn;
        logic        tlb_exception;
        logic [6:0]  expcode;
        logic        wen_expcode;
        logic [31:0] era;
        logic        wen_era;
        logic [31:0] badv;
        logic        wen_badv;
    } exc_req_t;

    typedef struct packed {
        logic [29:0] initval;
        logic        periodic;
        logic        en;
    } tcfg_t;

endpackage

// ==== exception/csr_exc_regs.sv ====
`timescale 1ns/1ns
module csr_exc_regs (
    input  logic              clk,
    input  logic              aresetn,
    input  csr_pkg::csr_wr_t  wr,
    input  csr_pkg::exc_req_t exc,
    input  logic [7:0]        hw_int,
    input  logic              timer_int,
    output csr_pkg::crmd_t    crmd,
    output logic [31:0]       prmd,
    output logic [31:0]       ecfg,
    output csr_pkg::estat_t   estat,
    output logic [31:0]       era,
    output logic [31:0]       badv,
    output logic [31:0]       eentry,
    output logic              cpu_interrupt,
    output logic              idle_over
);
    logic           exc_d;
    logic           exc_edge;
    logic [1:0]     pplv;
    logic           pie;
    logic [12:0]    lie;
    logic [1:0]     is_soft;
    logic [5:0]     ecode;
    logic [8:0]     esubcode;
    logic [25:0]    eentry_va;
    logic           wr_crmd;
    logic           wr_prmd;
    logic           wr_ecfg;
    logic           wr_estat;
    logic           wr_era;
    logic           wr_badv;
    logic           wr_eentry;
    csr_pkg::crmd_t crmd_wdata;

    assign exc_edge   = exc.exception & ~exc_d;
    assign crmd_wdata = wr.data;

    assign wr_crmd   = wr.en && wr.addr == csr_pkg::CSR_CRMD;
    assign wr_prmd   = wr.en && wr.addr == csr_pkg::CSR_PRMD;
    assign wr_ecfg   = wr.en && wr.addr == csr_pkg::CSR_ECFG;
    assign wr_estat  = wr.en && wr.addr == csr_pkg::CSR_ESTAT;
    assign wr_era    = wr.en && wr.addr == csr_pkg::CSR_ERA;
    assign wr_badv   = wr.en && wr.addr == csr_pkg::CSR_BADV;
    assign wr_eentry = wr.en && wr.addr == csr_pkg::CSR_EENTRY;

    always_ff @(posedge clk) begin
        if (!aresetn) begin
            exc_d <= 1'b0;
        end else begin
            exc_d <= exc.exception;
        end
    end

    // ertn over exception entry over software write
    always_ff @(posedge clk) begin
        if (!aresetn) begin
            crmd <= csr_pkg::CRMD_RESET;
        end else if (exc.ertn) begin
            crmd.plv <= pplv;
            crmd.ie  <= pie;
            if (ecode == csr_pkg::ECODE_TLBR) begin
                crmd.da <= 1'b0;
                crmd.pg <= 1'b1;
            end
        end else if (exc_edge) begin
            crmd.plv <= 2'b00;
            crmd.ie  <= 1'b0;
            if (exc.tlb_exception) begin
                crmd.da <= 1'b1;
                crmd.pg <= 1'b0;
            end
        end else if (wr_crmd) begin
            crmd.plv  <= crmd_wdata.plv;
            crmd.ie   <= crmd_wdata.ie;
            crmd.datf <= crmd_wdata.datf;
            crmd.datm <= crmd_wdata.datm;
            // Only direct or paged, never both or neither
            if (crmd_wdata.pg ^ crmd_wdata.da) begin
                crmd.pg <= crmd_wdata.pg;
                crmd.da <= crmd_wdata.da;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!aresetn) begin
            pplv      <= 2'b00;
            pie       <= 1'b0;
            lie       <= '0;
            is_soft   <= 2'b00;
            ecode     <= '0;
            esubcode  <= '0;
            era       <= '0;
            badv      <= '0;
            eentry_va <= '0;
        end else begin
            if (exc_edge) begin
                pplv <= crmd.plv;
                pie  <= crmd.ie;
            end else if (wr_prmd) begin
                pplv <= wr.data[1:0];
                pie  <= wr.data[2];
            end
            if (wr_ecfg) begin
                lie <= wr.data[12:0] & csr_pkg::LIE_MASK;
            end
            if (exc.wen_expcode || exc_edge) begin
                ecode    <= exc.expcode[5:0];
                esubcode <= (exc.expcode[5:0] == 6'd0) ? 9'd0 : {8'd0, exc.expcode[6]};
            end else if (wr_estat) begin
                is_soft <= wr.data[1:0];
            end
            if (exc.wen_era) begin
                era <= exc.era;
            end else if (wr_era) begin
                era <= wr.data;
            end
            if (exc.wen_badv) begin
                badv <= exc.badv;
            end else if (wr_badv) begin
                badv <= wr.data;
            end
            if (wr_eentry) begin
                eentry_va <= wr.data[31:6];
            end
        end
    end

    always_comb begin
        estat          = '0;
        estat.is_soft  = is_soft;
        estat.is_hard  = hw_int;
        estat.is_ti    = timer_int;
        estat.ecode    = ecode;
        estat.esubcode = esubcode;
    end

    assign prmd   = {29'd0, pie, pplv};
    assign ecfg   = {19'd0, lie};
    assign eentry = {eentry_va, 6'd0};

    assign cpu_interrupt = crmd.ie & (|(lie & estat[12:0]));
    // Any pending line wakes the core, enabled or not
    assign idle_over     = |estat[12:0];
endmodule

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module csr_tb -f build.f -o csr_sim

out=$(./obj_dir/csr_sim)
echo "$out"
echo "$out" | grep -qx "TEST OK"

// ==== source/csr_read_mux.sv ====
`timescale 1ns/1ns
module csr_read_mux #(
    parameter int N_SAVE = 4
) (
    input  logic [csr_pkg::CSR_ADDR_W-1:0]            addr_in,
    input  csr_pkg::crmd_t                            crmd,
    input  logic [31:0]                               prmd,
    input  logic [31:0]                               ecfg,
    input  csr_pkg::estat_t                           estat,
    input  logic [31:0]                               era,
    input  logic [31:0]                               badv,
    input  logic [31:0]                               eentry,
    input  logic [N_SAVE-1:0][csr_pkg::CSR_DATA_W-1:0] save,
    input  logic [31:0]                               tid,
    input  csr_pkg::tcfg_t                            tcfg,
    input  logic [31:0]                               tval,
    output logic [31:0]                               rdata
);
    localparam int AW = csr_pkg::CSR_ADDR_W;

    always_comb begin
        rdata = '0;
        case (addr_in)
            csr_pkg::CSR_CRMD:   rdata = crmd;
            csr_pkg::CSR_PRMD:   rdata = prmd;
            csr_pkg::CSR_ECFG:   rdata = ecfg;
            csr_pkg::CSR_ESTAT:  rdata = estat;
            csr_pkg::CSR_ERA:    rdata = era;
            csr_pkg::CSR_BADV:   rdata = badv;
            csr_pkg::CSR_EENTRY: rdata = eentry;
            csr_pkg::CSR_TID:    rdata = tid;
            csr_pkg::CSR_TCFG:   rdata = tcfg;
            csr_pkg::CSR_TVAL:   rdata = tval;
            // TICLR is write-only
            default:             rdata = '0;
        endcase
        for (int i = 0; i < N_SAVE; i++) begin
            if (addr_in == csr_pkg::CSR_SAVE0 + AW'(i)) begin
                rdata = save[i];
            end
        end
    end
endmodule

// ==== source/csr_save_regs.sv ====
`timescale 1ns/1ns
module csr_save_regs #(
    parameter int N_SAVE = 4
) (
    input  logic                                     clk,
    input  logic                                     aresetn,
    input  csr_pkg::csr_wr_t                         wr,
    output logic [N_SAVE-1:0][csr_pkg::CSR_DATA_W-1:0] save,
    output logic [csr_pkg::CSR_DATA_W-1:0]           tid
);
    localparam int AW = csr_pkg::CSR_ADDR_W;

    always_ff @(posedge clk) begin
        if (!aresetn) begin
            save <= '0;
            tid  <= '0;
        end else if (wr.en) begin
            // SAVE bank sits at consecutive addresses
            for (int i = 0; i < N_SAVE; i++) begin
                if (wr.addr == csr_pkg::CSR_SAVE0 + AW'(i)) begin
                    save[i] <= wr.data;
                end
            end
            if (wr.addr == csr_pkg::CSR_TID) begin
                tid <= wr.data;
            end
        end
    end
endmodule

// ==== source/csr_top.sv ====
`timescale 1ns/1ns
module csr_top #(
    parameter int TIMER_BITS = 32,
    parameter int N_SAVE     = 4
) (
    input  logic                            clk,
    input  logic                            aresetn,
    input  logic                            wen_in,
    input  logic [csr_pkg::CSR_ADDR_W-1:0]  addr_in,
    input  logic [csr_pkg::CSR_DATA_W-1:0]  wdata_in,
    input  logic                            d_idle,
    input  logic                            flush,
    input  csr_pkg::exc_req_t               exc,
    input  logic [7:0]                      hw_int,
    output logic [31:0]                     rdata,
    output logic                            wen_csr,
    output csr_pkg::crmd_t                  crmd,
    output csr_pkg::estat_t                 estat,
    output logic [31:0]                     era,
    output logic [31:0]                     eentry,
    output logic                            cpu_interrupt,
    output logic                            idle_over,
    output logic                            pg
);
    csr_pkg::csr_wr_t                          wr;
    csr_pkg::tcfg_t                            tcfg;
    logic [31:0]                               prmd;
    logic [31:0]                               ecfg;
    logic [31:0]                               badv;
    logic [31:0]                               tval;
    logic [31:0]                               tid;
    logic [N_SAVE-1:0][csr_pkg::CSR_DATA_W-1:0] save;
    logic                                      timer_int;

    csr_write_stage u_write_stage (
        .clk      (clk),
        .aresetn  (aresetn),
        .wen_in   (wen_in),
        .addr_in  (addr_in),
        .wdata_in (wdata_in),
        .d_idle   (d_idle),
        .flush    (flush),
        .wen_csr  (wen_csr),
        .wr       (wr)
    );

    csr_exc_regs u_exc_regs (
        .clk           (clk),
        .aresetn       (aresetn),
        .wr            (wr),
        .exc           (exc),
        .hw_int        (hw_int),
        .timer_int     (timer_int),
        .crmd          (crmd),
        .prmd          (prmd),
        .ecfg          (ecfg),
        .estat         (estat),
        .era           (era),
        .badv          (badv),
        .eentry        (eentry),
        .cpu_interrupt (cpu_interrupt),
        .idle_over     (idle_over)
    );

    csr_timer #(.TIMER_BITS(TIMER_BITS)) u_timer (
        .clk       (clk),
        .aresetn   (aresetn),
        .wr        (wr),
        .tcfg      (tcfg),
        .tval      (tval),
        .timer_int (timer_int)
    );

    csr_save_regs #(.N_SAVE(N_SAVE)) u_save_regs (
        .clk     (clk),
        .aresetn (aresetn),
        .wr      (wr),
        .save    (save),
        .tid     (tid)
    );

    csr_read_mux #(.N_SAVE(N_SAVE)) u_read_mux (
        .addr_in (addr_in),
        .crmd    (crmd),
        .prmd    (prmd),
        .ecfg    (ecfg),
        .estat   (estat),
        .era     (era),
        .badv    (badv),
        .eentry  (eentry),
        .save    (save),
        .tid     (tid),
        .tcfg    (tcfg),
        .tval    (tval),
        .rdata   (rdata)
    );

    // Paged translation flag for the MMU
    assign pg = crmd.pg;
endmodule

// ==== source/csr_write_stage.sv ====
`timescale 1ns/1ns
module csr_write_stage (
    input  logic                            clk,
    input  logic                            aresetn,
    input  logic                            wen_in,
    input  logic [csr_pkg::CSR_ADDR_W-1:0]  addr_in,
    input  logic [csr_pkg::CSR_DATA_W-1:0]  wdata_in,
    input  logic                            d_idle,
    input  logic                            flush,
    output logic                            wen_csr,
    output csr_pkg::csr_wr_t                wr
);
    logic                           pending;
    logic                           release_q;
    logic [csr_pkg::CSR_ADDR_W-1:0] addr_q;
    logic [csr_pkg::CSR_DATA_W-1:0] data_q;

    // First idle cycle of a pending write, once only
    assign wen_csr = pending & d_idle & ~release_q;

    always_ff @(posedge clk) begin
        if (!aresetn) begin
            pending   <= 1'b0;
            release_q <= 1'b0;
        end else if (flush) begin
            pending   <= 1'b0;
            release_q <= 1'b0;
        end else begin
            release_q <= wen_csr;
            if (wen_in) begin
                pending <= 1'b1;
            end else if (release_q) begin
                pending <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wen_in) begin
            addr_q <= addr_in;
            data_q <= wdata_in;
        end
    end

    always_comb begin
        wr.en   = release_q;
        wr.addr = addr_q;
        wr.data = data_q;
    end
endmodule

// ==== timer/csr_timer.sv ====
`timescale 1ns/1ns
module csr_timer #(
    parameter int TIMER_BITS = 32
) (
    input  logic             clk,
    input  logic             aresetn,
    input  csr_pkg::csr_wr_t wr,
    output csr_pkg::tcfg_t   tcfg,
    output logic [31:0]      tval,
    output logic             timer_int
);
    logic [TIMER_BITS-1:0] count;
    logic                  reload;
    logic                  time_out;
    logic                  wr_tcfg;
    logic                  wr_ticlr;

    assign wr_tcfg  = wr.en && wr.addr == csr_pkg::CSR_TCFG;
    assign wr_ticlr = wr.en && wr.addr == csr_pkg::CSR_TICLR;

    always_ff @(posedge clk) begin
        if (!aresetn) begin
            tcfg   <= '0;
            reload <= 1'b0;
        end else begin
            reload <= wr_tcfg;
            if (wr_tcfg) begin
                tcfg <= wr.data;
            end
        end
    end

    // Countdown, reload on new config or periodic wrap
    always_ff @(posedge clk) begin
        if (!aresetn) begin
            count    <= '0;
            time_out <= 1'b0;
        end else if (reload || count == '0) begin
            time_out <= 1'b0;
            if (reload || tcfg.periodic) begin
                count <= TIMER_BITS'(tcfg.initval);
            end
        end else if (tcfg.en) begin
            count    <= count - 1'b1;
            time_out <= (count == TIMER_BITS'(1));
        end
    end

    always_ff @(posedge clk) begin
        if (!aresetn) begin
            timer_int <= 1'b0;
        end else if (wr_ticlr) begin
            timer_int <= 1'b0;
        end else if (time_out) begin
            timer_int <= 1'b1;
        end
    end

    assign tval = 32'(count);
endmodule

// ==== verif/csr_chk.sv ====
`timescale 1ns/1ns
module csr_chk (
    input logic           clk,
    input logic           aresetn,
    input logic           wen_csr,
    input csr_pkg::crmd_t crmd,
    input logic           cpu_interrupt
);
    // One release per pending write
    wen_csr_single: assert property (@(posedge clk) disable iff (!aresetn)
        wen_csr |=> !wen_csr)
        else $error("wen_csr high in two consecutive cycles");

    // Exactly one of direct and paged translation
    crmd_mode_legal: assert property (@(posedge clk) disable iff (!aresetn)
        crmd.da != crmd.pg)
        else $error("crmd da and pg are equal");

    irq_needs_ie: assert property (@(posedge clk) disable iff (!aresetn)
        cpu_interrupt |-> crmd.ie)
        else $error("cpu_interrupt raised with crmd ie clear");
endmodule

bind csr_top csr_chk u_chk (
    .clk           (clk),
    .aresetn       (aresetn),
    .wen_csr       (wen_csr),
    .crmd          (crmd),
    .cpu_interrupt (cpu_interrupt)
);

// ==== verif/csr_tb.sv ====
`timescale 1ns/1ns
module csr_tb;
    localparam int CLK_HALF    = 10;
    localparam int N_TESTS     = 6;
    localparam int TIMER_N     = 5;
    localparam int WATCHDOG_NS = (N_TESTS * 200 + TIMER_N) * 2 * CLK_HALF;
    localparam logic [31:0] SEED = 32'hf929_2c42;
    localparam logic [13:0] SAVE1 = csr_pkg::CSR_SAVE0 + 14'd1;

    logic              clk;
    logic              aresetn;
    logic              wen_in;
    logic [13:0]       addr_in;
    logic [31:0]       wdata_in;
    logic              d_idle;
    logic              flush;
    csr_pkg::exc_req_t exc;
    logic [7:0]        hw_int;
    logic [31:0]       rdata;
    logic              wen_csr;
    csr_pkg::crmd_t    crmd;
    csr_pkg::estat_t   estat;
    logic [31:0]       era;
    logic [31:0]       eentry;
    logic              cpu_interrupt;
    logic              idle_over;
    logic              pg;
    int                errors;
    int                checks;

    csr_top #(.TIMER_BITS(32), .N_SAVE(4)) uut (
        .clk           (clk),
        .aresetn       (aresetn),
        .wen_in        (wen_in),
        .addr_in       (addr_in),
        .wdata_in      (wdata_in),
        .d_idle        (d_idle),
        .flush         (flush),
        .exc           (exc),
        .hw_int        (hw_int),
        .rdata         (rdata),
        .wen_csr       (wen_csr),
        .crmd          (crmd),
        .estat         (estat),
        .era           (era),
        .eentry        (eentry),
        .cpu_interrupt (cpu_interrupt),
        .idle_over     (idle_over),
        .pg            (pg)
    );

    always #CLK_HALF clk = ~clk;

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            $display("Error: %s got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic report_failure(input string what);
        $display("Error: %s", what);
        errors++;
    endtask

    // Issue a write, then hold the pipeline idle until it lands
    task automatic csr_write(input logic [13:0] addr, input logic [31:0] data);
        int waited;
        @(negedge clk);
        wen_in   = 1'b1;
        addr_in  = addr;
        wdata_in = data;
        @(negedge clk);
        wen_in = 1'b0;
        d_idle = 1'b1;
        waited = 0;
        #1;
        while (!wen_csr && waited < 20) begin
            @(negedge clk);
            #1;
            waited++;
        end
        if (!wen_csr) begin
            report_failure($sformatf("write to %h was never released", addr));
        end
        repeat (2) @(negedge clk);
        d_idle = 1'b0;
    endtask

    task automatic csr_read(input logic [13:0] addr, output logic [31:0] data);
        @(negedge clk);
        addr_in = addr;
        #1;
        data = rdata;
    endtask

    task automatic read_expect(input logic [13:0] addr, input logic [31:0] exp);
        logic [31:0] got;
        csr_read(addr, got);
        check($sformatf("rdata@%h", addr), got, exp);
    endtask

    task automatic raise_exception(input logic [6:0] code, input logic tlb);
        @(negedge clk);
        exc.exception     = 1'b1;
        exc.expcode       = code;
        exc.tlb_exception = tlb;
        @(negedge clk);
        exc = '0;
    endtask

    task automatic return_from_exception;
        @(negedge clk);
        exc.ertn = 1'b1;
        @(negedge clk);
        exc.ertn = 1'b0;
    endtask

    task automatic test_plain_regs;
        logic [13:0] addr_list [7];
        logic [31:0] data_list [7];
        logic [31:0] exp;
        addr_list = '{csr_pkg::CSR_SAVE0, SAVE1, csr_pkg::CSR_SAVE0 + 14'd2,
                      csr_pkg::CSR_SAVE0 + 14'd3, csr_pkg::CSR_TID, csr_pkg::CSR_ERA,
                      csr_pkg::CSR_BADV};
        for (int i = 0; i < 7; i++) begin
            data_list[i] = $urandom;
            csr_write(addr_list[i], data_list[i]);
        end
        for (int i = 0; i < 7; i++) begin
            read_expect(addr_list[i], data_list[i]);
        end
        check("era", era, data_list[5]);
        // EENTRY is 64-byte aligned
        exp = $urandom;
        csr_write(csr_pkg::CSR_EENTRY, exp);
        read_expect(csr_pkg::CSR_EENTRY, exp & 32'hffff_ffc0);
        check("eentry", eentry, exp & 32'hffff_ffc0);
    endtask

    task automatic test_write_staging;
        logic [31:0] old_val;
        logic [31:0] new_val;
        logic [31:0] got;
        csr_read(SAVE1, old_val);
        new_val = ~old_val;
        @(negedge clk);
        wen_in   = 1'b1;
        addr_in  = SAVE1;
        wdata_in = new_val;
        @(negedge clk);
        wen_in = 1'b0;
        repeat (5) begin
            csr_read(SAVE1, got);
            check("rdata", got, old_val);
            check("wen_csr", {31'd0, wen_csr}, 32'd0);
        end
        @(negedge clk);
        flush = 1'b1;
        @(negedge clk);
        flush  = 1'b0;
        d_idle = 1'b1;
        repeat (5) begin
            csr_read(SAVE1, got);
            check("rdata", got, old_val);
            check("wen_csr", {31'd0, wen_csr}, 32'd0);
        end
        d_idle = 1'b0;
        csr_write(SAVE1, new_val);
        read_expect(SAVE1, new_val);
    endtask

    task automatic test_interrupts;
        logic [31:0] got;
        @(negedge clk);
        hw_int = 8'ha5;
        csr_read(csr_pkg::CSR_ESTAT, got);
        check("estat.is_hard", {24'd0, got[9:2]}, 32'h0000_00a5);
        check("idle_over", {31'd0, idle_over}, 32'd1);
        check("cpu_interrupt", {31'd0, cpu_interrupt}, 32'd0);
        csr_write(csr_pkg::CSR_ECFG, 32'hffff_ffff);
        read_expect(csr_pkg::CSR_ECFG, 32'h0000_1fff & ~32'h0000_0400);
        check("cpu_interrupt", {31'd0, cpu_interrupt}, 32'd0);
        // ie=1 with the reset translation mode
        csr_write(csr_pkg::CSR_CRMD, 32'h0000_006c);
        #1;
        check("cpu_interrupt", {31'd0, cpu_interrupt}, 32'd1);
        @(negedge clk);
        hw_int = 8'h00;
        #1;
        check("cpu_interrupt", {31'd0, cpu_interrupt}, 32'd0);
        check("idle_over", {31'd0, idle_over}, 32'd0);
        hw_int = 8'h01;
        csr_write(csr_pkg::CSR_ECFG, 32'h0000_0000);
        #1;
        check("cpu_interrupt", {31'd0, cpu_interrupt}, 32'd0);
        check("idle_over", {31'd0, idle_over}, 32'd1);
        hw_int = 8'h00;
        csr_write(csr_pkg::CSR_CRMD, 32'h0000_0068);
    endtask

    task automatic test_exceptions;
        logic [31:0] got;
        csr_write(csr_pkg::CSR_CRMD, 32'h0000_006f);
        raise_exception(7'h0a, 1'b0);
        read_expect(csr_pkg::CSR_PRMD, 32'h0000_0007);
        read_expect(csr_pkg::CSR_CRMD, 32'h0000_006f & ~32'h0000_0007);
        check("crmd", crmd, 32'h0000_006f & ~32'h0000_0007);
        csr_read(csr_pkg::CSR_ESTAT, got);
        check("estat.ecode", {26'd0, got[21:16]}, 32'h0000_000a);
        check("estat.esubcode", {23'd0, got[30:22]}, 32'd0);
        return_from_exception();
        read_expect(csr_pkg::CSR_CRMD, 32'h0000_006f);
        // TLB refill drops to direct mode, ertn returns to paged
        raise_exception({1'b0, csr_pkg::ECODE_TLBR}, 1'b1);
        read_expect(csr_pkg::CSR_CRMD, 32'h0000_0068);
        check("crmd", crmd, 32'h0000_0068);
        check("pg", {31'd0, pg}, 32'd0);
        return_from_exception();
        read_expect(csr_pkg::CSR_CRMD, (32'h0000_006f & ~32'h0000_0008) | 32'h0000_0010);
        check("pg", {31'd0, pg}, 32'd1);
    endtask

    task automatic test_crmd_legality;
        logic [31:0] prev;
        logic [31:0] wval;
        csr_read(csr_pkg::CSR_CRMD, prev);
        wval = 32'h0000_007a;
        csr_write(csr_pkg::CSR_CRMD, wval);
        read_expect(csr_pkg::CSR_CRMD, (wval & ~32'h0000_0018) | (prev & 32'h0000_0018));
        csr_read(csr_pkg::CSR_CRMD, prev);
        wval = 32'h0000_0061;
        csr_write(csr_pkg::CSR_CRMD, wval);
        read_expect(csr_pkg::CSR_CRMD, (wval & ~32'h0000_0018) | (prev & 32'h0000_0018));
    endtask

    task automatic test_timer;
        logic [31:0] got;
        int          waited;
        logic        seen;
        csr_write(csr_pkg::CSR_TCFG, {30'(TIMER_N), 2'b01});
        waited = 0;
        #1;
        while (!estat.is_ti && waited < TIMER_N + 4) begin
            @(negedge clk);
            #1;
            waited++;
        end
        if (!estat.is_ti) begin
            report_failure($sformatf("timer interrupt did not rise within %0d cycles",
                                     TIMER_N + 4));
        end
        csr_write(csr_pkg::CSR_TICLR, 32'h0000_0001);
        csr_read(csr_pkg::CSR_ESTAT, got);
        check("estat.is_ti", {31'd0, got[11]}, 32'd0);
        // Disabled timer holds its initial count
        csr_write(csr_pkg::CSR_TCFG, {30'(TIMER_N), 2'b00});
        read_expect(csr_pkg::CSR_TVAL, 32'(TIMER_N));
        seen = 1'b0;
        repeat (2 * TIMER_N) begin
            @(negedge clk);
            #1;
            seen = seen | estat.is_ti;
        end
        check("estat.is_ti", {31'd0, seen}, 32'd0);
    endtask

    initial begin
        clk      = 1'b0;
        aresetn  = 1'b0;
        wen_in   = 1'b0;
        addr_in  = '0;
        wdata_in = '0;
        d_idle   = 1'b0;
        flush    = 1'b0;
        exc      = '0;
        hw_int   = '0;
        errors   = 0;
        checks   = 0;
        void'($urandom(SEED));
        repeat (3) @(posedge clk);
        @(negedge clk);
        aresetn = 1'b1;

        test_plain_regs();
        test_write_staging();
        test_interrupts();
        test_exceptions();
        test_crmd_legality();
        test_timer();

        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: the tests did not finish within %0d ns", WATCHDOG_NS);
        $display("TEST FAILED");
        $finish;
    end
endmodule
